// File: Makefile
# Verilator flow for the read reorder subsystem

VERILATOR  ?= verilator
TOP        := read_reorder_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulation binary exits with a failing status on any fatal check
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: hw/line_req_splitter.sv
// Request splitter that turns a multi-line read into one slot allocation and fabric read per line
`timescale 1ns/1ps

module line_req_splitter
(
    input  logic                clk,
    input  logic                reset,

    // Client request, taken when busy is low
    input  logic                req_en,
    input  rob_pkg::req_id_t    req_id,
    input  rob_pkg::line_addr_t req_addr,
    input  rob_pkg::line_cnt_t  req_lines,
    output logic                busy,

    // Slot allocation in the reorder buffer
    rob_alloc_if.requester      alloc_port,

    // Fabric read, tagged with the granted slot
    output logic                fab_req_en,
    output rob_pkg::line_addr_t fab_req_addr,
    output rob_pkg::rob_idx_t   fab_req_tag
);

    rob_pkg::split_state_t state;

    // Latched request
    rob_pkg::req_id_t    id_q;
    rob_pkg::line_addr_t base_q;
    rob_pkg::line_cnt_t  last_q;

    // Line currently being issued
    rob_pkg::line_cnt_t  line_q;
    logic                issue;

    assign busy = (state == rob_pkg::SPLIT_ISSUE);

    // One line goes out in every busy cycle with a free slot
    assign issue = busy && alloc_port.not_full;

    assign alloc_port.alloc      = issue;
    assign alloc_port.alloc_meta = {id_q, line_q};
    assign fab_req_en            = issue;
    assign fab_req_tag           = alloc_port.alloc_idx;
    assign fab_req_addr          = base_q + rob_pkg::line_addr_t'(line_q);

    // ========================================
    // FSM
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= rob_pkg::SPLIT_IDLE;
            line_q <= '0;
        end
        else
        begin
            case (state)
                rob_pkg::SPLIT_IDLE:
                begin
                    if (req_en)
                    begin
                        state  <= rob_pkg::SPLIT_ISSUE;
                        line_q <= '0;
                    end
                end
                rob_pkg::SPLIT_ISSUE:
                begin
                    // Without a free slot everything simply holds
                    if (alloc_port.not_full)
                    begin
                        if (line_q == last_q)
                        begin
                            state <= rob_pkg::SPLIT_IDLE;
                        end
                        line_q <= line_q + 1'b1;
                    end
                end
                default:
                begin
                    state <= rob_pkg::SPLIT_IDLE;
                end
            endcase
        end
    end

    // Request fields are captured only when the request is accepted
    always_ff @(posedge clk)
    begin
        if (!busy && req_en)
        begin
            id_q   <= req_id;
            base_q <= req_addr;
            last_q <= req_lines;
        end
    end

endmodule

// File: hw/read_reorder_top.sv
// Read reorder subsystem top joining the request splitter and the reorder buffer
`timescale 1ns/1ps

module read_reorder_top
(
    input  logic                clk,
    input  logic                reset,

    // ========================================
    // Client request
    // ========================================

    // Taken in a cycle with req_en high and busy low
    input  logic                req_en,
    input  rob_pkg::req_id_t    req_id,
    input  rob_pkg::line_addr_t req_addr,
    // Number of lines minus one
    input  rob_pkg::line_cnt_t  req_lines,
    output logic                busy,

    // ========================================
    // Fabric side
    // ========================================

    // One read per line, tag is the reorder slot
    output logic                fab_req_en,
    output rob_pkg::line_addr_t fab_req_addr,
    output rob_pkg::rob_idx_t   fab_req_tag,

    // Responses in any order, no ready
    input  logic                rsp_en,
    input  rob_pkg::rob_idx_t   rsp_tag,
    input  rob_pkg::rob_data_t  rsp_data,

    // ========================================
    // Ordered output
    // ========================================

    // first_data and first_meta are valid two cycles after a dequeue
    input  logic                deq_en,
    output logic                not_empty,
    output rob_pkg::rob_data_t  first_data,
    output rob_pkg::rob_meta_t  first_meta
);

    // Slot allocation channel between the two blocks
    rob_alloc_if u_alloc (.clk(clk));

    line_req_splitter u_splitter
    (
        .clk          (clk),
        .reset        (reset),
        .req_en       (req_en),
        .req_id       (req_id),
        .req_addr     (req_addr),
        .req_lines    (req_lines),
        .busy         (busy),
        .alloc_port   (u_alloc.requester),
        .fab_req_en   (fab_req_en),
        .fab_req_addr (fab_req_addr),
        .fab_req_tag  (fab_req_tag)
    );

    read_rob u_rob
    (
        .clk          (clk),
        .reset        (reset),
        .alloc_port   (u_alloc.buffer),
        .rsp_en       (rsp_en),
        .rsp_tag      (rsp_tag),
        .rsp_data     (rsp_data),
        .deq_en       (deq_en),
        .not_empty    (not_empty),
        .first_data   (first_data),
        .first_meta   (first_meta)
    );

endmodule

// File: hw/read_rob.sv
// Read reorder buffer that grants slots in order, stores responses by tag and returns lines in order
`timescale 1ns/1ps
`include "rob_params.svh"

module read_rob
(
    input  logic               clk,
    input  logic               reset,

    // Slot allocation from the splitter
    rob_alloc_if.buffer        alloc_port,

    // Fabric responses, always accepted
    input  logic               rsp_en,
    input  rob_pkg::rob_idx_t  rsp_tag,
    input  rob_pkg::rob_data_t rsp_data,

    // Ordered output, data and meta follow a dequeue by two cycles
    input  logic               deq_en,
    output logic               not_empty,
    output rob_pkg::rob_data_t first_data,
    output rob_pkg::rob_meta_t first_meta
);

    // ========================================
    // Ring pointers
    // ========================================

    // Both pointers carry a wrap bit above the slot index
    rob_pkg::rob_ptr_t newest;
    rob_pkg::rob_ptr_t oldest;
    rob_pkg::rob_ptr_t used;
    rob_pkg::rob_idx_t oldest_idx;
    rob_pkg::rob_idx_t oldest_next_idx;

    assign oldest_idx = rob_pkg::rob_idx_t'(oldest);
    assign oldest_next_idx = oldest_idx + 1'b1;

    // Occupancy, correct across the wrap thanks to the extra bit
    assign used = newest - oldest;

    // An allocation is allowed only if ROB_MIN_FREE slots remain free afterwards
    assign alloc_port.not_full =
        (used + rob_pkg::rob_ptr_t'(`ROB_MIN_FREE)) < rob_pkg::rob_ptr_t'(`ROB_ENTRIES);

    // The granted slot is simply the newest pointer
    assign alloc_port.alloc_idx = rob_pkg::rob_idx_t'(newest);

    // The slot under the oldest pointer is freed at the dequeue edge
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            newest <= '0;
            oldest <= '0;
        end
        else
        begin
            if (alloc_port.alloc)
            begin
                newest <= newest + 1'b1;
            end
            if (deq_en)
            begin
                oldest <= oldest + 1'b1;
            end
        end
    end

    // ========================================
    // Response tracking
    // ========================================

    logic [`ROB_ENTRIES-1:0] valid_next;
    logic [`ROB_ENTRIES-1:0] valid_q;
    // Valid bits of oldest (bit 0) and oldest+1 (bit 1), sampled a cycle ago
    logic [1:0]              valid_pair_q;
    logic                    deq_en_q;
    rob_pkg::rob_idx_t       oldest_q;
    logic                    reset_q;

    // If the head moved on last cycle the slot after it is now the head
    assign not_empty = valid_pair_q[deq_en_q];

    always_comb
    begin
        valid_next = valid_q;
        // A dequeued slot is cleared one cycle late, before it can be reused
        if (deq_en_q)
        begin
            valid_next[oldest_q] = 1'b0;
        end
        // Arriving response marks its slot
        if (rsp_en)
        begin
            valid_next[rsp_tag] = 1'b1;
        end
    end

    // The wide valid array clears under a delayed copy of reset.
    // Nothing can be dequeued in the first cycle after reset anyway
    always_ff @(posedge clk)
    begin
        reset_q <= reset;
    end

    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            valid_q      <= '0;
            valid_pair_q <= 2'b00;
            deq_en_q     <= 1'b0;
        end
        else
        begin
            valid_q      <= valid_next;
            deq_en_q     <= deq_en;
            valid_pair_q <= {valid_q[oldest_next_idx], valid_q[oldest_idx]};
        end
        oldest_q <= oldest_idx;
    end

    // ========================================
    // Data and meta storage
    // ========================================

    // Line data is written at the response tag
    rob_ram #(.WIDTH($bits(rob_pkg::rob_data_t))) u_data_ram
    (
        .clk   (clk),
        .wen   (rsp_en),
        .waddr (rsp_tag),
        .wdata (rsp_data),
        .raddr (oldest_idx),
        .rdata (first_data)
    );

    // Meta-data is written at the slot being granted
    rob_ram #(.WIDTH($bits(rob_pkg::rob_meta_t))) u_meta_ram
    (
        .clk   (clk),
        .wen   (alloc_port.alloc),
        .waddr (alloc_port.alloc_idx),
        .wdata (alloc_port.alloc_meta),
        .raddr (oldest_idx),
        .rdata (first_meta)
    );

endmodule

// File: hw/rob_alloc_if.sv
// Slot allocation channel between the request splitter and the reorder buffer
`timescale 1ns/1ps

interface rob_alloc_if
(
    input logic clk
);

    // One-cycle strobe, one slot per strobe
    logic alloc;
    // Meta-data stored in the granted slot
    rob_pkg::rob_meta_t alloc_meta;
    // Level that allows an allocation in the current cycle
    logic not_full;
    // Slot granted when alloc is high in the same cycle
    rob_pkg::rob_idx_t alloc_idx;

    // The splitter asks for slots and reads back the granted index
    modport requester
    (
        input  clk,
        output alloc,
        output alloc_meta,
        input  not_full,
        input  alloc_idx
    );

    // The reorder buffer grants slots from its newest pointer
    modport buffer
    (
        input  clk,
        input  alloc,
        input  alloc_meta,
        output not_full,
        output alloc_idx
    );

endinterface

// File: hw/rob_pkg.sv
// Read reorder package holding the shared vector types and the splitter state encoding
`include "rob_params.svh"

package rob_pkg;

    // Slot index into the reorder buffer, also used as the fabric tag
    typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_idx_t;

    // Slot index with one extra wrap bit so full and empty can be told apart
    typedef logic [$clog2(`ROB_ENTRIES):0] rob_ptr_t;

    // Payload types
    typedef logic [`ROB_DATA_BITS-1:0] rob_data_t;
    typedef logic [`ROB_ADDR_BITS-1:0] line_addr_t;
    typedef logic [`ROB_ID_BITS-1:0] req_id_t;

    // Holds the number of lines minus one
    typedef logic [`ROB_CNT_BITS-1:0] line_cnt_t;

    // Meta-data saved at allocation, with the request id above the line number
    typedef logic [`ROB_ID_BITS+`ROB_CNT_BITS-1:0] rob_meta_t;

    // Splitter FSM: waiting for a request, or issuing its lines one per cycle
    typedef enum logic
    {
        SPLIT_IDLE,
        SPLIT_ISSUE
    } split_state_t;

endpackage

// File: hw/rob_ram.sv
// Reorder storage array with a synchronous write and a two-stage registered read path
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_ram
#(
    parameter int WIDTH = 64
)
(
    input  logic              clk,

    // Write port
    input  logic              wen,
    input  rob_pkg::rob_idx_t waddr,
    input  logic [WIDTH-1:0]  wdata,

    // Read port, data appears two cycles after raddr
    input  rob_pkg::rob_idx_t raddr,
    output logic [WIDTH-1:0]  rdata
);

    // ========================================
    // Storage
    // ========================================

    logic [WIDTH-1:0] mem [`ROB_ENTRIES];

    // First read stage, straight out of the array
    logic [WIDTH-1:0] rd_q;

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // ========================================
    // Read path
    // ========================================

    // The array read is registered and then passes one more output stage.
    // A read of the address being written returns the old word
    always_ff @(posedge clk)
    begin
        rd_q  <= mem[raddr];
        rdata <= rd_q;
    end

endmodule

// File: include/rob_params.svh
// Read reorder parameters covering buffer geometry, field widths and the allocation threshold
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// ========================================
// Buffer geometry
// ========================================

// Number of reorder slots, which must be a power of two
`define ROB_ENTRIES 16

// Slots that must remain free after an allocation for not_full to stay high
`define ROB_MIN_FREE 1

// ========================================
// Field widths
// ========================================

// One memory line of read data
`define ROB_DATA_BITS 64

// Line address, counted in lines and not in bytes
`define ROB_ADDR_BITS 32

// Client request id, returned with every line as meta-data
`define ROB_ID_BITS 4

// Line count of a request, encoded as count minus one (1 to 4 lines)
`define ROB_CNT_BITS 2

`endif

// File: project.f
+incdir+include
hw/rob_pkg.sv
hw/rob_alloc_if.sv
hw/rob_ram.sv
hw/read_rob.sv
hw/line_req_splitter.sv
hw/read_reorder_top.sv
sim/clk_gen.sv
sim/read_reorder_props.sv
sim/read_reorder_tb.sv

// File: sim/clk_gen.sv
// Testbench clock and reset source with a 20 ns period and a two-cycle reset
`timescale 1ns/1ps

module clk_gen
(
    output logic clk,
    output logic reset
);

    // Free-running clock, 10 ns per half period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10;
            clk = ~clk;
        end
    end

    // Reset covers the first two rising edges and drops just after the second
    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

// File: sim/read_reorder_props.sv
// Protocol properties of the read reorder subsystem, bound onto its top level
`timescale 1ns/1ps

module read_reorder_props
(
    input logic clk,
    input logic reset,
    input logic alloc,
    input logic not_full,
    input logic fab_req_en,
    input logic deq_en,
    input logic not_empty,
    input logic busy
);

    // A slot is only granted while the buffer still has room
    alloc_needs_room: assert property (@(posedge clk) disable iff (reset) alloc |-> not_full)
        else $error("Slot allocated while the reorder buffer was full");

    // The ordered output is only popped while a line is ready
    deq_needs_line: assert property (@(posedge clk) disable iff (reset) deq_en |-> not_empty)
        else $error("Dequeue issued while the reorder buffer had no ready line");

    // Every fabric read goes with exactly one slot allocation
    read_matches_alloc: assert property (@(posedge clk) disable iff (reset) fab_req_en == alloc)
        else $error("Fabric read strobe and slot allocation strobe disagree");

    // The splitter comes out of reset idle
    idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy)
        else $error("Splitter was busy in the first cycle after reset");

endmodule

// Attach the properties to the subsystem, reaching into the allocation channel
bind read_reorder_top read_reorder_props u_props
(
    .clk        (clk),
    .reset      (reset),
    .alloc      (u_alloc.alloc),
    .not_full   (u_alloc.not_full),
    .fab_req_en (fab_req_en),
    .deq_en     (deq_en),
    .not_empty  (not_empty),
    .busy       (busy)
);

// File: sim/read_reorder_stim.txt
# Columns: request id (hex), start line address (hex), line count from 1 to 4
# The first four requests need 16 slots, so the buffer fills while the drain waits
1 00001000 4
2 00002000 4
3 00003000 4
4 00004000 4
5 00005000 1
6 00006010 2
7 00007020 3
8 00008030 4
9 0000a000 1
a 0000b100 1
b 0000c200 2
c 0000d300 4
d 0000e400 3
e 0000f500 2
f 10000000 4
0 20000004 1
1 fffffffe 4
2 12345678 3
3 00000000 2
4 7ffffffd 4
5 abcdef00 1
6 0badc0de 2
7 55aa55aa 4
8 deadbee0 3
9 00100000 4
a 00200000 4
b 00300000 4
c 00400000 4
d 00500000 2
e 00600000 1
f 00700000 3

// File: sim/read_reorder_tb.sv
// Read reorder testbench with a file-driven client, an out-of-order fabric model and a scoreboard
`timescale 1ns/1ps
`include "rob_params.svh"

module read_reorder_tb;

    logic                clk;
    logic                reset;

    logic                req_en;
    rob_pkg::req_id_t    req_id;
    rob_pkg::line_addr_t req_addr;
    rob_pkg::line_cnt_t  req_lines;
    logic                busy;
    logic                fab_req_en;
    rob_pkg::line_addr_t fab_req_addr;
    rob_pkg::rob_idx_t   fab_req_tag;
    logic                rsp_en;
    rob_pkg::rob_idx_t   rsp_tag;
    rob_pkg::rob_data_t  rsp_data;
    logic                deq_en;
    logic                not_empty;
    rob_pkg::rob_data_t  first_data;
    rob_pkg::rob_meta_t  first_meta;

    // Requests as read from the file, count kept as 1 to 4
    rob_pkg::req_id_t    stim_id[$];
    rob_pkg::line_addr_t stim_addr[$];
    int                  stim_lines[$];

    // Expected fabric reads and ordered output lines
    rob_pkg::line_addr_t exp_addr_q[$];
    rob_pkg::rob_data_t  exp_data_q[$];
    rob_pkg::rob_meta_t  exp_meta_q[$];

    // Fabric model, one outstanding read per tag
    logic                pend_valid[`ROB_ENTRIES];
    rob_pkg::line_addr_t pend_addr[`ROB_ENTRIES];
    int                  pend_delay[`ROB_ENTRIES];
    rob_pkg::rob_idx_t   next_tag;

    logic [31:0]         rng;
    logic [1:0]          deq_pipe;
    logic                started;
    logic                drain_on;
    logic                stim_loaded;
    int                  req_idx;
    int                  blocked_cycles;
    int                  cycle_count;
    int                  timeout_cycles;

    clk_gen u_clk_gen
    (
        .clk   (clk),
        .reset (reset)
    );

    read_reorder_top u_dut
    (
        .clk          (clk),
        .reset        (reset),
        .req_en       (req_en),
        .req_id       (req_id),
        .req_addr     (req_addr),
        .req_lines    (req_lines),
        .busy         (busy),
        .fab_req_en   (fab_req_en),
        .fab_req_addr (fab_req_addr),
        .fab_req_tag  (fab_req_tag),
        .rsp_en       (rsp_en),
        .rsp_tag      (rsp_tag),
        .rsp_data     (rsp_data),
        .deq_en       (deq_en),
        .not_empty    (not_empty),
        .first_data   (first_data),
        .first_meta   (first_meta)
    );

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Fabric data rule: address on top, its inverse below
    function automatic rob_pkg::rob_data_t line_data(input rob_pkg::line_addr_t addr);
        return {addr, ~addr};
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic load_stimulus();
        int          fd;
        int          got;
        int          rc;
        string       text;
        logic [31:0] id_f;
        logic [31:0] addr_f;
        logic [31:0] lines_f;
        fd = $fopen("sim/read_reorder_stim.txt", "r");
        assert (fd != 0) else stop_run("Could not open the stimulus file");
        while (!$feof(fd))
        begin
            rc = $fgets(text, fd);
            // Lines starting with a hash are column notes
            if (rc > 0 && text.getc(0) != "#")
            begin
                got = $sscanf(text, "%h %h %h", id_f, addr_f, lines_f);
                if (got == 3)
                begin
                    assert (lines_f >= 1 && lines_f <= 4)
                        else stop_run("Stimulus line count outside 1 to 4");
                    stim_id.push_back(rob_pkg::req_id_t'(id_f));
                    stim_addr.push_back(addr_f);
                    stim_lines.push_back(int'(lines_f));
                end
            end
        end
        $fclose(fd);
        assert (stim_id.size() > 0) else stop_run("Stimulus file holds no requests");
    endtask

    // Every request expands into its lines in file order
    task automatic build_expected();
        rob_pkg::line_addr_t addr;
        foreach (stim_id[r])
        begin
            for (int l = 0; l < stim_lines[r]; l++)
            begin
                addr = stim_addr[r] + rob_pkg::line_addr_t'(l);
                exp_addr_q.push_back(addr);
                exp_data_q.push_back(line_data(addr));
                exp_meta_q.push_back({stim_id[r], rob_pkg::line_cnt_t'(l)});
            end
        end
    endtask

    // ========================================
    // Drivers, 2 ns after the rising edge
    // ========================================

    task automatic drive_request();
        // A request driven last cycle was seen with busy low, so it was taken
        if (req_en)
        begin
            req_en = 1'b0;
            req_idx++;
        end
        else if (!busy && req_idx < stim_id.size())
        begin
            req_en    = 1'b1;
            req_id    = stim_id[req_idx];
            req_addr  = stim_addr[req_idx];
            req_lines = rob_pkg::line_cnt_t'(stim_lines[req_idx] - 1);
            started   = 1'b1;
        end
    endtask

    task automatic drive_response();
        rsp_en = 1'b0;
        for (int i = 0; i < `ROB_ENTRIES; i++)
        begin
            if (pend_valid[i] && pend_delay[i] > 0)
            begin
                pend_delay[i]--;
            end
        end
        // One response per cycle, whichever read has matured first by index
        for (int i = 0; i < `ROB_ENTRIES; i++)
        begin
            if (!rsp_en && pend_valid[i] && pend_delay[i] == 0)
            begin
                rsp_en        = 1'b1;
                rsp_tag       = rob_pkg::rob_idx_t'(i);
                rsp_data      = line_data(pend_addr[i]);
                pend_valid[i] = 1'b0;
            end
        end
    endtask

    // Drain pops on most cycles with a line ready, skipping about one in four
    task automatic drive_drain();
        rng    = lcg_next(rng);
        deq_en = drain_on && not_empty && (rng[17:16] != 2'b00);
    endtask

    // ========================================
    // Monitors, sampled at the falling edge
    // ========================================

    task automatic capture_fabric_read();
        rob_pkg::line_addr_t exp_addr;
        assert (exp_addr_q.size() > 0) else stop_run("Fabric read issued beyond the requested lines");
        exp_addr = exp_addr_q.pop_front();
        assert (fab_req_addr == exp_addr)
            else stop_run($sformatf("ERROR fab_req_addr: got %h expected %h", fab_req_addr, exp_addr));
        // Slots are granted in ring order
        assert (fab_req_tag == next_tag)
            else stop_run($sformatf("ERROR fab_req_tag: got %h expected %h", fab_req_tag, next_tag));
        assert (!pend_valid[fab_req_tag]) else stop_run("Fabric tag reused while still outstanding");
        next_tag = next_tag + 1'b1;
        rng = lcg_next(rng);
        pend_valid[fab_req_tag] = 1'b1;
        pend_addr[fab_req_tag]  = fab_req_addr;
        pend_delay[fab_req_tag] = 1 + int'(rng[18:16]);
    endtask

    task automatic check_output();
        rob_pkg::rob_data_t exp_data;
        rob_pkg::rob_meta_t exp_meta;
        assert (exp_meta_q.size() > 0) else stop_run("A line was dequeued with nothing left to expect");
        exp_data = exp_data_q.pop_front();
        exp_meta = exp_meta_q.pop_front();
        assert (first_meta == exp_meta)
            else stop_run($sformatf("ERROR first_meta: got %h expected %h", first_meta, exp_meta));
        assert (first_data == exp_data)
            else stop_run($sformatf("ERROR first_data: got %h expected %h", first_data, exp_data));
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (!started)
            begin
                assert (!busy && !fab_req_en && !not_empty)
                    else stop_run("Outputs were not idle between reset and the first request");
            end
            // Data follows an accepted dequeue by exactly two cycles
            if (deq_pipe[1])
            begin
                check_output();
            end
            deq_pipe = {deq_pipe[0], deq_en && not_empty};
            if (fab_req_en)
            begin
                capture_fabric_read();
            end
            // The drain waits until the splitter has been held by a full buffer
            if (busy && !fab_req_en)
            begin
                blocked_cycles++;
                if (blocked_cycles >= 8)
                begin
                    drain_on = 1'b1;
                end
            end
        end
    end

    // ========================================
    // Run control
    // ========================================

    initial
    begin
        wait (stim_loaded);
        forever
        begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > timeout_cycles)
            begin
                stop_run($sformatf("Run timed out with %0d lines still expected", exp_meta_q.size()));
            end
        end
    end

    initial
    begin
        req_en      = 1'b0;
        req_id      = '0;
        req_addr    = '0;
        req_lines   = '0;
        rsp_en      = 1'b0;
        rsp_tag     = '0;
        rsp_data    = '0;
        deq_en      = 1'b0;
        rng         = 32'h695a;
        deq_pipe    = 2'b00;
        started     = 1'b0;
        drain_on    = 1'b0;
        stim_loaded = 1'b0;
        next_tag    = '0;
        req_idx     = 0;
        cycle_count = 0;
        blocked_cycles = 0;
        for (int i = 0; i < `ROB_ENTRIES; i++)
        begin
            pend_valid[i] = 1'b0;
            pend_addr[i]  = '0;
            pend_delay[i] = 0;
        end
        load_stimulus();
        build_expected();
        timeout_cycles = 40 * stim_id.size() + 200;
        stim_loaded = 1'b1;
        @(negedge reset);
        while (exp_meta_q.size() > 0)
        begin
            @(posedge clk);
            #2;
            drive_request();
            drive_response();
            drive_drain();
        end
        assert (drain_on) else stop_run("The splitter was never held by a full buffer");
        assert (exp_addr_q.size() == 0) else stop_run("Fewer fabric reads were issued than lines");
        $display("All checks passed");
        $finish;
    end

endmodule
